// ==== glb_pkg.sv ====
package glb_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // register map
  ////////////////////////////////////////////////////////////////////////////
  typedef enum logic [11:0] {
    HW_VERSION  = 12'h000,   // ro
    INTR_MASK   = 12'h004,   // rw
    INTR_SET    = 12'h008,   // wo, reads as zero
    INTR_STATUS = 12'h00c    // rw, write 1 to clear
  } glb_reg_e;

  // one status bit per unit and ping-pong group
  localparam int INTR_W = 8;
  typedef logic [INTR_W-1:0] glb_intr_vec_t;

  typedef enum logic [2:0] {
    SDP0      = 3'd0,
    SDP1      = 3'd1,
    CDMA_DAT0 = 3'd2,
    CDMA_DAT1 = 3'd3,
    CDMA_WT0  = 3'd4,
    CDMA_WT1  = 3'd5,
    CACC0     = 3'd6,
    CACC1     = 3'd7
  } glb_src_e;

  ////////////////////////////////////////////////////////////////////////////
  // csb packets
  ////////////////////////////////////////////////////////////////////////////
  localparam int REQ_ADDR_LSB  = 0;
  localparam int REQ_ADDR_MSB  = 21;
  localparam int REQ_WDAT_LSB  = 22;
  localparam int REQ_WDAT_MSB  = 53;
  localparam int REQ_WRITE_BIT = 54;
  localparam int REQ_NPOST_BIT = 55;
  localparam int REQ_PRIV_BIT  = 56;
  localparam int REQ_BE_LSB    = 57;
  localparam int REQ_BE_MSB    = 60;
  localparam int REQ_LVL_LSB   = 61;
  localparam int REQ_LVL_MSB   = 62;

  localparam int RESP_KIND_BIT = 33;
  localparam int RESP_ERR_BIT  = 32;
  localparam int RESP_DATA_MSB = 31;

  typedef logic [62:0] glb_req_t;
  typedef logic [33:0] glb_resp_t;

  typedef enum logic {RESP_READ = 1'b0, RESP_WRITE = 1'b1} glb_resp_kind_e;

endpackage

// ==== glb_csb.sv ====
`timescale 1ns/1ps
module glb_csb (
  input  logic               nvdla_core_clk,
  input  logic               nvdla_core_rstn,
  input  logic               csb2glb_req_pvld,
  input  glb_pkg::glb_req_t  csb2glb_req_pd,
  input  logic [31:0]        reg_rd_data,
  output logic               csb2glb_req_prdy,
  output logic               glb2csb_resp_valid,
  output glb_pkg::glb_resp_t glb2csb_resp_pd,
  output logic [11:0]        reg_offset,
  output logic               reg_wr_en,
  output logic [31:0]        reg_wr_data
);

  logic                    req_vld;
  glb_pkg::glb_req_t       req_pd;
  logic [9:0]              req_word;    // word index inside the block
  logic                    req_write;
  logic                    req_nposted;
  logic [31:0]             req_wdat;
  logic                    rsp_rd_vld;
  logic                    rsp_wr_vld;
  logic                    rsp_vld;
  glb_pkg::glb_resp_kind_e rsp_kind;
  logic [31:0]             rsp_data;
  glb_pkg::glb_resp_t      rsp_pd;

  ////////////////////////////////////////////////////////////////////////////
  // request stage
  ////////////////////////////////////////////////////////////////////////////
  assign csb2glb_req_prdy = 1'b1;   // never back-pressures

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      req_vld <= 1'b0;
    end else begin
      req_vld <= csb2glb_req_pvld;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (csb2glb_req_pvld) begin
      req_pd <= csb2glb_req_pd;   // payload, held until next request
    end
  end

  // field unpack
  assign req_word    = req_pd[glb_pkg::REQ_ADDR_LSB+9:glb_pkg::REQ_ADDR_LSB];
  assign req_write   = req_pd[glb_pkg::REQ_WRITE_BIT];
  assign req_nposted = req_pd[glb_pkg::REQ_NPOST_BIT];
  assign req_wdat    = req_pd[glb_pkg::REQ_WDAT_MSB:glb_pkg::REQ_WDAT_LSB];

  // register access, byte offset from word index
  assign reg_offset  = {req_word, 2'b00};
  assign reg_wr_en   = req_vld & req_write;
  assign reg_wr_data = req_wdat;

  ////////////////////////////////////////////////////////////////////////////
  // response stage
  ////////////////////////////////////////////////////////////////////////////
  assign rsp_rd_vld = req_vld & ~req_write;
  assign rsp_wr_vld = req_vld & req_write & req_nposted;   // posted writes stay silent
  assign rsp_vld    = rsp_rd_vld | rsp_wr_vld;

  assign rsp_kind = req_write ? glb_pkg::RESP_WRITE : glb_pkg::RESP_READ;
  assign rsp_data = req_write ? 32'd0 : reg_rd_data;   // write ack carries no data

  always_comb begin
    rsp_pd = '0;
    rsp_pd[glb_pkg::RESP_KIND_BIT]    = rsp_kind;
    rsp_pd[glb_pkg::RESP_ERR_BIT]     = 1'b0;   // no error path
    rsp_pd[glb_pkg::RESP_DATA_MSB:0]  = rsp_data;
  end

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      glb2csb_resp_valid <= 1'b0;
    end else begin
      glb2csb_resp_valid <= rsp_vld;   // one-cycle strobe
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (rsp_vld) begin
      glb2csb_resp_pd <= rsp_pd;
    end
  end

endmodule

// ==== glb_reg.sv ====
`timescale 1ns/1ps
module glb_reg #(
  parameter logic [31:0] hw_version = 32'h0003_1001
) (
  input  logic                   nvdla_core_clk,
  input  logic                   nvdla_core_rstn,
  input  logic [11:0]            reg_offset,
  input  logic                   reg_wr_en,
  input  logic [31:0]            reg_wr_data,
  input  glb_pkg::glb_intr_vec_t intr_status,
  output logic [31:0]            reg_rd_data,
  output glb_pkg::glb_intr_vec_t intr_mask,
  output glb_pkg::glb_intr_vec_t status_clr,
  output glb_pkg::glb_intr_vec_t status_set
);

  logic                   sel_version;
  logic                   sel_mask;
  logic                   sel_set;
  logic                   sel_status;
  glb_pkg::glb_intr_vec_t wr_vec;

  ////////////////////////////////////////////////////////////////////////////
  // address decode
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    sel_version = 1'b0;
    sel_mask    = 1'b0;
    sel_set     = 1'b0;
    sel_status  = 1'b0;
    case (reg_offset)
      glb_pkg::HW_VERSION:  sel_version = 1'b1;
      glb_pkg::INTR_MASK:   sel_mask    = 1'b1;
      glb_pkg::INTR_SET:    sel_set     = 1'b1;
      glb_pkg::INTR_STATUS: sel_status  = 1'b1;
      default: ;   // unmapped, no select
    endcase
  end

  assign wr_vec = reg_wr_data[glb_pkg::INTR_W-1:0];

  ////////////////////////////////////////////////////////////////////////////
  // mask register
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      intr_mask <= '0;
    end else if (reg_wr_en && sel_mask) begin
      intr_mask <= wr_vec;
    end
  end

  // single-cycle strobes into the status logic
  assign status_clr = (reg_wr_en && sel_status) ? wr_vec : '0;
  assign status_set = (reg_wr_en && sel_set) ? wr_vec : '0;

  ////////////////////////////////////////////////////////////////////////////
  // read mux
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    reg_rd_data = 32'd0;
    if (sel_version) begin
      reg_rd_data = hw_version;
    end else if (sel_mask) begin
      reg_rd_data = {{(32-glb_pkg::INTR_W){1'b0}}, intr_mask};
    end else if (sel_status) begin
      reg_rd_data = {{(32-glb_pkg::INTR_W){1'b0}}, intr_status};   // live value
    end
    // set register is write-only, reads fall through to zero
  end

endmodule

// ==== glb_intr.sv ====
`timescale 1ns/1ps
module glb_intr (
  input  logic                   nvdla_core_clk,
  input  logic                   nvdla_core_rstn,
  input  logic [1:0]             sdp_done,
  input  logic [1:0]             cdma_dat_done,
  input  logic [1:0]             cdma_wt_done,
  input  logic [1:0]             cacc_done,
  input  glb_pkg::glb_intr_vec_t status_clr,
  input  glb_pkg::glb_intr_vec_t status_set,
  input  glb_pkg::glb_intr_vec_t intr_mask,
  output glb_pkg::glb_intr_vec_t intr_status,
  output logic                   core_intr
);

  glb_pkg::glb_intr_vec_t done_vec;
  glb_pkg::glb_intr_vec_t status_nxt;
  glb_pkg::glb_intr_vec_t status_unmasked;

  ////////////////////////////////////////////////////////////////////////////
  // done pulse packing
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    done_vec = '0;
    done_vec[glb_pkg::SDP0]      = sdp_done[0];
    done_vec[glb_pkg::SDP1]      = sdp_done[1];
    done_vec[glb_pkg::CDMA_DAT0] = cdma_dat_done[0];
    done_vec[glb_pkg::CDMA_DAT1] = cdma_dat_done[1];
    done_vec[glb_pkg::CDMA_WT0]  = cdma_wt_done[0];
    done_vec[glb_pkg::CDMA_WT1]  = cdma_wt_done[1];
    done_vec[glb_pkg::CACC0]     = cacc_done[0];
    done_vec[glb_pkg::CACC1]     = cacc_done[1];
  end

  ////////////////////////////////////////////////////////////////////////////
  // status register
  ////////////////////////////////////////////////////////////////////////////
  // clear first, then or in sets, so a set on the same bit wins
  assign status_nxt = (intr_status & ~status_clr) | done_vec | status_set;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      intr_status <= '0;
    end else begin
      intr_status <= status_nxt;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // interrupt line
  ////////////////////////////////////////////////////////////////////////////
  assign status_unmasked = intr_status & ~intr_mask;   // mask bit 1 hides source

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      core_intr <= 1'b0;
    end else begin
      core_intr <= |status_unmasked;   // lags status by one edge
    end
  end

endmodule

// ==== nv_glb.sv ====
`timescale 1ns/1ps
module nv_glb #(
  parameter logic [31:0] hw_version = 32'h0003_1001
) (
  input  logic               nvdla_core_clk,
  input  logic               nvdla_core_rstn,
  input  logic               csb2glb_req_pvld,
  input  glb_pkg::glb_req_t  csb2glb_req_pd,
  output logic               csb2glb_req_prdy,
  output logic               glb2csb_resp_valid,
  output glb_pkg::glb_resp_t glb2csb_resp_pd,
  input  logic [1:0]         sdp_done,
  input  logic [1:0]         cdma_dat_done,
  input  logic [1:0]         cdma_wt_done,
  input  logic [1:0]         cacc_done,
  output logic               core_intr
);

  logic [11:0]            reg_offset;
  logic                   reg_wr_en;
  logic [31:0]            reg_wr_data;
  logic [31:0]            reg_rd_data;
  glb_pkg::glb_intr_vec_t intr_mask;
  glb_pkg::glb_intr_vec_t status_clr;
  glb_pkg::glb_intr_vec_t status_set;
  glb_pkg::glb_intr_vec_t intr_status;

  glb_csb u_csb (
    .nvdla_core_clk     (nvdla_core_clk),
    .nvdla_core_rstn    (nvdla_core_rstn),
    .csb2glb_req_pvld   (csb2glb_req_pvld),
    .csb2glb_req_pd     (csb2glb_req_pd),
    .reg_rd_data        (reg_rd_data),
    .csb2glb_req_prdy   (csb2glb_req_prdy),
    .glb2csb_resp_valid (glb2csb_resp_valid),
    .glb2csb_resp_pd    (glb2csb_resp_pd),
    .reg_offset         (reg_offset),
    .reg_wr_en          (reg_wr_en),
    .reg_wr_data        (reg_wr_data)
  );

  glb_reg #(.hw_version(hw_version)) u_reg (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .reg_offset      (reg_offset),
    .reg_wr_en       (reg_wr_en),
    .reg_wr_data     (reg_wr_data),
    .intr_status     (intr_status),
    .reg_rd_data     (reg_rd_data),
    .intr_mask       (intr_mask),
    .status_clr      (status_clr),
    .status_set      (status_set)
  );

  glb_intr u_intr (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .sdp_done        (sdp_done),
    .cdma_dat_done   (cdma_dat_done),
    .cdma_wt_done    (cdma_wt_done),
    .cacc_done       (cacc_done),
    .status_clr      (status_clr),
    .status_set      (status_set),
    .intr_mask       (intr_mask),
    .intr_status     (intr_status),
    .core_intr       (core_intr)
  );

endmodule

// ==== tb_glb.sv ====
`timescale 1ns/1ps
module tb_glb;

  localparam logic [31:0] HW_VER    = 32'h0003_1001;
  localparam int          MAX_CYCLE = 600;   // tests take about 270 cycles

  logic                   nvdla_core_clk;
  logic                   nvdla_core_rstn;
  logic                   csb2glb_req_pvld;
  glb_pkg::glb_req_t      csb2glb_req_pd;
  logic                   csb2glb_req_prdy;
  logic                   glb2csb_resp_valid;
  glb_pkg::glb_resp_t     glb2csb_resp_pd;
  logic [1:0]             sdp_done;
  logic [1:0]             cdma_dat_done;
  logic [1:0]             cdma_wt_done;
  logic [1:0]             cacc_done;
  logic                   core_intr;

  string                  test_name;
  integer                 seed;
  int                     cycles = 0;
  glb_pkg::glb_intr_vec_t exp_status;   // model of the status register
  glb_pkg::glb_intr_vec_t exp_mask;     // model of the mask register
  glb_pkg::glb_resp_t     rsp;
  glb_pkg::glb_resp_t     rsp2;

  nv_glb #(.hw_version(HW_VER)) u_nv_glb (
    .nvdla_core_clk     (nvdla_core_clk),
    .nvdla_core_rstn    (nvdla_core_rstn),
    .csb2glb_req_pvld   (csb2glb_req_pvld),
    .csb2glb_req_pd     (csb2glb_req_pd),
    .csb2glb_req_prdy   (csb2glb_req_prdy),
    .glb2csb_resp_valid (glb2csb_resp_valid),
    .glb2csb_resp_pd    (glb2csb_resp_pd),
    .sdp_done           (sdp_done),
    .cdma_dat_done      (cdma_dat_done),
    .cdma_wt_done       (cdma_wt_done),
    .cacc_done          (cacc_done),
    .core_intr          (core_intr)
  );

  initial begin
    nvdla_core_clk = 1'b0;
    forever #2 nvdla_core_clk = ~nvdla_core_clk;
  end

  always @(posedge nvdla_core_clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLE) begin
      abort_run("the run went past its cycle limit without finishing");
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_resp(input glb_pkg::glb_resp_t exp, input glb_pkg::glb_resp_t act);
    if (act !== exp) begin
      abort_run($sformatf("** Error [%s] response: expected %h, actual %h",
                          test_name, exp, act));
    end
  endtask

  task automatic check_intr_vec(input string what, input glb_pkg::glb_intr_vec_t exp,
                                input glb_pkg::glb_intr_vec_t act);
    if (act !== exp) begin
      abort_run($sformatf("** Error [%s] %s: expected %h, actual %h",
                          test_name, what, exp, act));
    end
  endtask

  task automatic check_intr(input logic exp);
    if (core_intr !== exp) begin
      abort_run($sformatf("** Error [%s] core_intr: expected %b, actual %b",
                          test_name, exp, core_intr));
    end
  endtask

  // core_intr trails a status change by one edge
  task automatic expect_core_intr();
    repeat (2) @(negedge nvdla_core_clk);
    check_intr(|(exp_status & ~exp_mask));   // mask bit 1 hides
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // bus and unit drivers
  ////////////////////////////////////////////////////////////////////////////
  function automatic glb_pkg::glb_req_t make_req(input logic [11:0] offset, input logic write,
                                                 input logic nposted, input logic [31:0] data);
    glb_pkg::glb_req_t pkt;
    pkt = '0;
    pkt[glb_pkg::REQ_ADDR_MSB:glb_pkg::REQ_ADDR_LSB] = {12'd0, offset[11:2]};   // word address
    pkt[glb_pkg::REQ_WDAT_MSB:glb_pkg::REQ_WDAT_LSB] = data;
    pkt[glb_pkg::REQ_WRITE_BIT] = write;
    pkt[glb_pkg::REQ_NPOST_BIT] = nposted;
    return pkt;
  endfunction

  function automatic glb_pkg::glb_resp_t make_resp(input glb_pkg::glb_resp_kind_e kind,
                                                   input logic [31:0] data);
    return {kind, 1'b0, data};   // error bit always clear
  endfunction

  function automatic glb_pkg::glb_src_e src_bit(input int unit, input int group);
    case (unit)
      0:       return (group == 0) ? glb_pkg::SDP0 : glb_pkg::SDP1;
      1:       return (group == 0) ? glb_pkg::CDMA_DAT0 : glb_pkg::CDMA_DAT1;
      2:       return (group == 0) ? glb_pkg::CDMA_WT0 : glb_pkg::CDMA_WT1;
      default: return (group == 0) ? glb_pkg::CACC0 : glb_pkg::CACC1;
    endcase
  endfunction

  task automatic send_req(input glb_pkg::glb_req_t pkt);
    @(posedge nvdla_core_clk);
    csb2glb_req_pvld <= 1'b1;
    csb2glb_req_pd   <= pkt;
    @(posedge nvdla_core_clk);   // accept edge
    csb2glb_req_pvld <= 1'b0;
  endtask

  task automatic wait_resp(output glb_pkg::glb_resp_t pd);
    @(negedge nvdla_core_clk);
    if (glb2csb_resp_valid) begin
      abort_run($sformatf("[%s] a response came one edge too early", test_name));
    end
    @(negedge nvdla_core_clk);
    if (!glb2csb_resp_valid) begin
      abort_run($sformatf("[%s] no response two edges after the request", test_name));
    end
    pd = glb2csb_resp_pd;
  endtask

  task automatic bus_write(input logic [11:0] offset, input logic [31:0] data,
                           input logic nposted);
    glb_pkg::glb_resp_t pd;
    send_req(make_req(offset, 1'b1, nposted, data));
    if (nposted) begin
      wait_resp(pd);
      check_resp(make_resp(glb_pkg::RESP_WRITE, 32'd0), pd);
    end else begin
      repeat (2) begin
        @(negedge nvdla_core_clk);
        if (glb2csb_resp_valid) begin
          abort_run($sformatf("[%s] a posted write returned a response", test_name));
        end
      end
    end
    if (offset == glb_pkg::INTR_MASK) exp_mask = data[glb_pkg::INTR_W-1:0];
    if (offset == glb_pkg::INTR_SET) exp_status = exp_status | data[glb_pkg::INTR_W-1:0];
    if (offset == glb_pkg::INTR_STATUS) exp_status = exp_status & ~data[glb_pkg::INTR_W-1:0];
  endtask

  task automatic bus_read(input logic [11:0] offset, output glb_pkg::glb_resp_t pd);
    send_req(make_req(offset, 1'b0, 1'b0, 32'd0));
    wait_resp(pd);
  endtask

  task automatic read_vec(input logic [11:0] offset, input glb_pkg::glb_intr_vec_t exp,
                          input string what);
    glb_pkg::glb_resp_t pd;
    bus_read(offset, pd);
    check_intr_vec(what, exp, pd[glb_pkg::INTR_W-1:0]);
    check_resp(make_resp(glb_pkg::RESP_READ, {24'd0, exp}), pd);
  endtask

  task automatic pulse_done(input int unit, input int group);
    logic [1:0] pat;
    pat = (group == 0) ? 2'b01 : 2'b10;
    @(posedge nvdla_core_clk);
    case (unit)
      0:       sdp_done      <= pat;
      1:       cdma_dat_done <= pat;
      2:       cdma_wt_done  <= pat;
      default: cacc_done     <= pat;
    endcase
    @(posedge nvdla_core_clk);   // status bit sets here
    sdp_done      <= 2'b00;
    cdma_dat_done <= 2'b00;
    cdma_wt_done  <= 2'b00;
    cacc_done     <= 2'b00;
    exp_status[src_bit(unit, group)] = 1'b1;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////////////////////
  task automatic test_reset();
    test_name = "reset";
    @(negedge nvdla_core_clk);
    if (csb2glb_req_prdy !== 1'b1) begin
      abort_run("[reset] request ready is not held high");
    end
    check_intr(1'b0);
    bus_read(glb_pkg::HW_VERSION, rsp);
    check_resp(make_resp(glb_pkg::RESP_READ, HW_VER), rsp);
    read_vec(glb_pkg::INTR_MASK, '0, "mask");
    read_vec(glb_pkg::INTR_STATUS, '0, "status");
    read_vec(glb_pkg::INTR_SET, '0, "set");   // write-only
  endtask

  task automatic test_write_resp();
    logic [31:0] data;
    test_name = "write_resp";
    bus_write(glb_pkg::INTR_MASK, 32'h0000_00a5, 1'b1);
    bus_write(glb_pkg::INTR_MASK, 32'h0000_005a, 1'b0);
    read_vec(glb_pkg::INTR_MASK, exp_mask, "mask");
    for (int i = 0; i < 16; i++) begin
      data = $random(seed);
      bus_write(glb_pkg::INTR_MASK, data, i[0]);
      read_vec(glb_pkg::INTR_MASK, exp_mask, "mask");
    end
    // two reads back to back, one in each stage
    @(posedge nvdla_core_clk);
    csb2glb_req_pvld <= 1'b1;
    csb2glb_req_pd   <= make_req(glb_pkg::HW_VERSION, 1'b0, 1'b0, 32'd0);
    @(posedge nvdla_core_clk);
    csb2glb_req_pd   <= make_req(glb_pkg::INTR_MASK, 1'b0, 1'b0, 32'd0);
    @(posedge nvdla_core_clk);
    csb2glb_req_pvld <= 1'b0;
    @(negedge nvdla_core_clk);
    if (!glb2csb_resp_valid) abort_run("[write_resp] first back-to-back read got no response");
    rsp = glb2csb_resp_pd;
    @(negedge nvdla_core_clk);
    if (!glb2csb_resp_valid) abort_run("[write_resp] second back-to-back read got no response");
    rsp2 = glb2csb_resp_pd;
    check_resp(make_resp(glb_pkg::RESP_READ, HW_VER), rsp);
    check_resp(make_resp(glb_pkg::RESP_READ, {24'd0, exp_mask}), rsp2);
    bus_write(glb_pkg::INTR_MASK, 32'd0, 1'b1);
  endtask

  task automatic test_done_capture();
    test_name = "done_capture";
    for (int u = 0; u < 4; u++) begin
      for (int g = 0; g < 2; g++) begin
        pulse_done(u, g);
        read_vec(glb_pkg::INTR_STATUS, exp_status, "status");
        expect_core_intr();
      end
    end
  endtask

  task automatic test_mask_clear();
    test_name = "mask_clear";
    bus_write(glb_pkg::INTR_MASK, 32'h0000_00ff, 1'b1);
    expect_core_intr();
    bus_write(glb_pkg::INTR_MASK, 32'h0000_000f, 1'b0);
    expect_core_intr();
    bus_write(glb_pkg::INTR_STATUS, 32'h0000_00f0, 1'b1);
    read_vec(glb_pkg::INTR_STATUS, exp_status, "status");
    expect_core_intr();
    bus_write(glb_pkg::INTR_STATUS, 32'h0000_0005, 1'b0);
    read_vec(glb_pkg::INTR_STATUS, exp_status, "status");
    bus_write(glb_pkg::INTR_MASK, 32'd0, 1'b1);
    expect_core_intr();
  endtask

  task automatic test_set_priority();
    glb_pkg::glb_intr_vec_t vec;
    test_name = "set_priority";
    bus_write(glb_pkg::INTR_STATUS, 32'h0000_00ff, 1'b1);
    expect_core_intr();
    bus_write(glb_pkg::INTR_SET, 32'h0000_0090, 1'b0);
    read_vec(glb_pkg::INTR_STATUS, exp_status, "status");
    read_vec(glb_pkg::INTR_SET, '0, "set");   // status nonzero, set still reads zero
    expect_core_intr();
    pulse_done(0, 0);
    vec = '0;
    vec[glb_pkg::SDP0]  = 1'b1;
    vec[glb_pkg::CACC1] = 1'b1;
    // clear lands in the same cycle as a new cacc group 1 pulse
    @(posedge nvdla_core_clk);
    csb2glb_req_pvld <= 1'b1;
    csb2glb_req_pd   <= make_req(glb_pkg::INTR_STATUS, 1'b1, 1'b0, {24'd0, vec});
    @(posedge nvdla_core_clk);
    csb2glb_req_pvld <= 1'b0;
    cacc_done        <= 2'b10;
    @(posedge nvdla_core_clk);
    cacc_done        <= 2'b00;
    exp_status = exp_status & ~vec;
    exp_status[glb_pkg::CACC1] = 1'b1;   // set wins
    read_vec(glb_pkg::INTR_STATUS, exp_status, "status");
  endtask

  task automatic test_unmapped();
    test_name = "unmapped";
    bus_read(12'h010, rsp);
    check_resp(make_resp(glb_pkg::RESP_READ, 32'd0), rsp);
    bus_write(12'h010, 32'hffff_ffff, 1'b1);
    read_vec(glb_pkg::INTR_MASK, exp_mask, "mask");
    read_vec(glb_pkg::INTR_STATUS, exp_status, "status");
  endtask

  initial begin
    seed = 32'he4da_b0f4;
    exp_status = '0;
    exp_mask   = '0;
    nvdla_core_rstn  <= 1'b0;
    csb2glb_req_pvld <= 1'b0;
    csb2glb_req_pd   <= '0;
    sdp_done         <= 2'b00;
    cdma_dat_done    <= 2'b00;
    cdma_wt_done     <= 2'b00;
    cacc_done        <= 2'b00;
    repeat (4) @(posedge nvdla_core_clk);
    nvdla_core_rstn  <= 1'b1;
    test_reset();
    test_write_resp();
    test_done_capture();
    test_mask_clear();
    test_set_priority();
    test_unmapped();
    $display("NO ERRORS");
    $finish;
  end

endmodule

// ==== all.f ====
glb_pkg.sv
glb_csb.sv
glb_reg.sv
glb_intr.sv
nv_glb.sv
tb_glb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_glb -f all.f -o sim_glb

out=$(./obj_dir/sim_glb 2>&1) || true
echo "$out"

if echo "$out" | grep -q "^NO ERRORS$"; then
  exit 0
fi
echo "simulation failed"
exit 1
